// ==== exePkg.sv ====
package exePkg;

	localparam int XLEN = 32;

	// data memory geometry, word addressed
	localparam int DMEMWORDS = 256;
	localparam int DMEMAW = $clog2(DMEMWORDS);

	// machine CSR addresses
	localparam logic [11:0] CSRMSCRATCH = 12'h340;
	localparam logic [11:0] CSRMEPC = 12'h341;
	localparam logic [11:0] CSRMCAUSE = 12'h342;
	localparam logic [11:0] CSRMTVEC = 12'h305;

	localparam logic [XLEN-1:0] CAUSEECALL = 32'd11;	// environment call from M-mode

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
	} aluOpT;

	// NOBR marks instructions with no branch condition
	typedef enum logic [2:0] {
		BEQ, BNE, BLT, BGE, BLTU, BGEU, NOBR
	} branchOpT;

	typedef enum logic [2:0] {
		WBALU    = 3'd0,
		WBLINK   = 3'd1,
		WBMULDIV = 3'd2,
		WBLUI    = 3'd3,
		WBMEM    = 3'd4,
		WBAUIPC  = 3'd5,
		WBCSR    = 3'd6
	} wbSelT;

	typedef enum logic [3:0] {
		MNONE, LB, LH, LW, LBU, LHU, SB, SH, SW
	} memOpT;

	typedef enum logic [2:0] {
		MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
	} mulDivOpT;

	// encoded as funct3 of the SYSTEM opcode
	typedef enum logic [2:0] {
		CNONE = 3'd0,
		CRW   = 3'd1,
		CRS   = 3'd2,
		CRC   = 3'd3,
		CRWI  = 3'd5,
		CRSI  = 3'd6,
		CRCI  = 3'd7
	} csrOpT;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input exePkg::aluOpT aluOp,
	input exePkg::branchOpT branchOp,
	input logic [exePkg::XLEN-1:0] a,
	input logic [exePkg::XLEN-1:0] b,
	output logic [exePkg::XLEN-1:0] result,
	output logic btaken
);
	import exePkg::*;

	logic eq;
	logic ltS;
	logic ltU;
	logic [4:0] shamt;

	assign eq = (a == b);
	assign ltS = ($signed(a) < $signed(b));
	assign ltU = (a < b);
	assign shamt = b[4:0];	// only the low five bits shift

	always_comb
	begin
		case (aluOp)
			ADD: result = a + b;
			SUB: result = a - b;
			SLL: result = a << shamt;
			SLT: result = {{(XLEN-1){1'b0}}, ltS};
			SLTU: result = {{(XLEN-1){1'b0}}, ltU};
			XOR: result = a ^ b;
			SRL: result = a >> shamt;
			SRA: result = $signed(a) >>> shamt;
			OR: result = a | b;
			AND: result = a & b;
			default: result = '0;
		endcase
	end

	// branch condition, shares the comparators
	always_comb
	begin
		case (branchOp)
			BEQ: btaken = eq;
			BNE: btaken = !eq;
			BLT: btaken = ltS;
			BGE: btaken = !ltS;
			BLTU: btaken = ltU;
			BGEU: btaken = !ltU;
			default: btaken = 1'b0;	// NOBR
		endcase
	end

endmodule

// ==== branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit (
	input logic [exePkg::XLEN-1:0] pc,
	input logic [exePkg::XLEN-1:0] a,
	input logic [exePkg::XLEN-1:0] bImm,
	input logic [exePkg::XLEN-1:0] jImm,
	input logic [exePkg::XLEN-1:0] iImm,
	input logic btaken,
	input logic jump,
	input logic jumpReg,
	output logic [exePkg::XLEN-1:0] target,
	output logic bjTaken
);
	import exePkg::*;

	logic [XLEN-1:0] jalrSum;

	assign jalrSum = a + iImm;

	always_comb
	begin
		if (jumpReg)
			target = {jalrSum[XLEN-1:1], 1'b0};	// jalr clears bit 0
		else if (jump)
			target = pc + jImm;
		else
			target = pc + bImm;
	end

	assign bjTaken = btaken | jump | jumpReg;

endmodule

// ==== dataMem.sv ====
`timescale 1ns/1ps

module dataMem (
	input logic clk,
	input logic nrst,
	input exePkg::memOpT memOp,
	input logic [exePkg::XLEN-1:0] base,
	input logic [exePkg::XLEN-1:0] storeData,
	input logic [exePkg::XLEN-1:0] offset,
	output logic [exePkg::XLEN-1:0] memOut,
	output logic addrMisaligned
);
	import exePkg::*;

	logic [XLEN-1:0] mem [DMEMWORDS];

	logic [XLEN-1:0] addr;
	logic [DMEMAW-1:0] wordIdx;
	logic isStore;
	logic misaligned;
	logic [3:0] byteEn;
	logic [XLEN-1:0] wrData;

	memOpT memOp5;
	logic [1:0] byteOff5;
	logic [XLEN-1:0] rdWord5;
	logic mis5;
	logic [7:0] laneByte;
	logic [15:0] laneHalf;
	logic [XLEN-1:0] loadVal;

	assign addr = base + offset;
	assign wordIdx = addr[DMEMAW+1:2];
	assign isStore = memOp inside {SB, SH, SW};
	assign misaligned = ((memOp inside {LH, LHU, SH}) && addr[0])
		|| ((memOp inside {LW, SW}) && (addr[1:0] != 2'b00));

	// lane enables and replicated store data
	always_comb
	begin
		case (memOp)
			SB: byteEn = 4'b0001 << addr[1:0];
			SH: byteEn = addr[1] ? 4'b1100 : 4'b0011;
			SW: byteEn = 4'b1111;
			default: byteEn = 4'b0000;
		endcase
		case (memOp)
			SB: wrData = {4{storeData[7:0]}};
			SH: wrData = {2{storeData[15:0]}};
			default: wrData = storeData;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (isStore && !misaligned)
			for (int i = 0; i < 4; i++)
				if (byteEn[i])
					mem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			memOp5 <= MNONE;
			byteOff5 <= '0;
			rdWord5 <= '0;
			mis5 <= 1'b0;
			memOut <= '0;
			addrMisaligned <= 1'b0;
		end
		else
		begin
			memOp5 <= memOp;
			byteOff5 <= addr[1:0];
			rdWord5 <= mem[wordIdx];	// old contents on a same-edge store
			mis5 <= misaligned;
			memOut <= loadVal;
			addrMisaligned <= mis5;
		end
	end

	always_comb
	begin
		laneByte = rdWord5[8*byteOff5 +: 8];
		laneHalf = rdWord5[16*byteOff5[1] +: 16];
		case (memOp5)
			LB: loadVal = {{24{laneByte[7]}}, laneByte};
			LBU: loadVal = {24'b0, laneByte};
			LH: loadVal = {{16{laneHalf[15]}}, laneHalf};
			LHU: loadVal = {16'b0, laneHalf};
			LW: loadVal = rdWord5;
			default: loadVal = '0;
		endcase
		if (mis5)
			loadVal = '0;	// flagged load returns nothing
	end

endmodule

// ==== mulDiv.sv ====
`timescale 1ns/1ps

module mulDiv (
	input logic [exePkg::XLEN-1:0] a,
	input logic [exePkg::XLEN-1:0] b,
	input exePkg::mulDivOpT op,
	output logic [exePkg::XLEN-1:0] res
);
	import exePkg::*;

	logic signed [XLEN-1:0] sa;
	logic signed [XLEN-1:0] sb;
	logic signed [2*XLEN+1:0] prodSS;
	logic signed [2*XLEN+1:0] prodSU;
	logic [2*XLEN-1:0] prodUU;
	logic divByZero;
	logic overflow;
	logic signed [XLEN-1:0] sQuot;
	logic signed [XLEN-1:0] sRem;
	logic [XLEN-1:0] uQuot;
	logic [XLEN-1:0] uRem;

	assign sa = a;
	assign sb = b;
	assign prodSS = sa * sb;
	assign prodSU = sa * $signed({1'b0, b});	// rs2 taken as unsigned
	assign prodUU = a * b;

	assign divByZero = (b == '0);
	assign overflow = (a == 32'h8000_0000) && (b == '1);	// most negative by -1

	always_comb
	begin
		sQuot = '0;
		sRem = '0;
		uQuot = '0;
		uRem = '0;
		if (!divByZero)
		begin
			uQuot = a / b;
			uRem = a % b;
			if (!overflow)
			begin
				sQuot = sa / sb;
				sRem = sa % sb;	// sign follows the dividend
			end
		end
		case (op)
			MUL: res = prodUU[XLEN-1:0];
			MULH: res = prodSS[2*XLEN-1:XLEN];
			MULHSU: res = prodSU[2*XLEN-1:XLEN];
			MULHU: res = prodUU[2*XLEN-1:XLEN];
			DIV: res = divByZero ? '1 : (overflow ? a : sQuot);
			DIVU: res = divByZero ? '1 : uQuot;
			REM: res = divByZero ? a : (overflow ? '0 : sRem);
			REMU: res = divByZero ? a : uRem;
			default: res = '0;
		endcase
	end

endmodule

// ==== csrUnit.sv ====
`timescale 1ns/1ps

module csrUnit (
	input logic clk,
	input logic nrst,
	input exePkg::csrOpT op,
	input logic [11:0] addr,
	input logic [exePkg::XLEN-1:0] rs1,
	input logic [exePkg::XLEN-1:0] imm,
	input logic ecall,
	input logic [exePkg::XLEN-1:0] pc,
	output logic [exePkg::XLEN-1:0] csrOld
);
	import exePkg::*;

	logic [XLEN-1:0] mscratch;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mcause;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] src;
	logic [XLEN-1:0] newVal;

	always_comb
	begin
		case (addr)
			CSRMSCRATCH: csrOld = mscratch;
			CSRMEPC: csrOld = mepc;
			CSRMCAUSE: csrOld = mcause;
			CSRMTVEC: csrOld = mtvec;
			default: csrOld = '0;	// unimplemented CSR
		endcase
	end

	assign src = (op inside {CRWI, CRSI, CRCI}) ? imm : rs1;

	always_comb
	begin
		case (op)
			CRW, CRWI: newVal = src;
			CRS, CRSI: newVal = csrOld | src;
			CRC, CRCI: newVal = csrOld & ~src;
			default: newVal = csrOld;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
			mtvec <= '0;
		end
		else
		begin
			if (op != CNONE)
			begin
				case (addr)
					CSRMSCRATCH: mscratch <= newVal;
					CSRMEPC: mepc <= newVal;
					CSRMCAUSE: mcause <= newVal;
					CSRMTVEC: mtvec <= newVal;
					default: ;
				endcase
			end
			// ecall wins over a CSR write in the same cycle
			if (ecall)
			begin
				mepc <= pc;
				mcause <= CAUSEECALL;
			end
		end
	end

endmodule

// ==== exeControl.sv ====
`timescale 1ns/1ps

module exeControl (
	input logic clk,
	input logic nrst,
	input logic [exePkg::XLEN-1:0] opA,
	input logic [exePkg::XLEN-1:0] opB,
	input logic [4:0] rd,
	input logic we,
	input exePkg::wbSelT wbSel,
	input exePkg::aluOpT aluOp,
	input exePkg::branchOpT branchOp,
	input logic jump,
	input logic jumpReg,
	input logic [exePkg::XLEN-1:0] bImm,
	input logic [exePkg::XLEN-1:0] jImm,
	input logic [exePkg::XLEN-1:0] uImm,
	input exePkg::mulDivOpT mulDivOp,
	input logic [exePkg::XLEN-1:0] pc,
	input exePkg::csrOpT csrOp,
	input logic [11:0] csrAddr,
	input logic [exePkg::XLEN-1:0] csrImm,
	input logic ecall,
	input logic [exePkg::XLEN-1:0] aluRes,
	input logic btaken,
	input logic [exePkg::XLEN-1:0] mulDivRes,
	input logic [exePkg::XLEN-1:0] csrOld,
	input logic [exePkg::XLEN-1:0] memRd,
	output logic [exePkg::XLEN-1:0] opA5,
	output logic [exePkg::XLEN-1:0] opB5,
	output exePkg::aluOpT aluOp5,
	output exePkg::branchOpT branchOp5,
	output exePkg::mulDivOpT mulDivOp5,
	output exePkg::csrOpT csrOp5,
	output logic [11:0] csrAddr5,
	output logic [exePkg::XLEN-1:0] csrImm5,
	output logic ecall5,
	output logic [exePkg::XLEN-1:0] pc5,
	output logic [exePkg::XLEN-1:0] bImm5,
	output logic [exePkg::XLEN-1:0] jImm5,
	output logic jump5,
	output logic jumpReg5,
	output logic [exePkg::XLEN-1:0] wbData,
	output logic [4:0] rdOut,
	output logic weOut
);
	import exePkg::*;

	logic [4:0] rd5;
	logic we5;
	wbSelT wbSel5;
	logic [XLEN-1:0] uImm5;

	wbSelT wbSel6;
	logic [XLEN-1:0] aluRes6;
	logic [XLEN-1:0] mulDiv6;
	logic [XLEN-1:0] csr6;
	logic [XLEN-1:0] lui6;
	logic [XLEN-1:0] auipc6;
	logic [XLEN-1:0] link6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5 <= '0;
			opB5 <= '0;
			rd5 <= '0;
			we5 <= 1'b0;
			wbSel5 <= WBALU;
			aluOp5 <= ADD;
			branchOp5 <= NOBR;	// no branch out of reset
			jump5 <= 1'b0;
			jumpReg5 <= 1'b0;
			bImm5 <= '0;
			jImm5 <= '0;
			uImm5 <= '0;
			mulDivOp5 <= MUL;
			pc5 <= '0;
			csrOp5 <= CNONE;
			csrAddr5 <= '0;
			csrImm5 <= '0;
			ecall5 <= 1'b0;
		end
		else
		begin
			opA5 <= opA;
			opB5 <= opB;
			rd5 <= rd;
			we5 <= we;
			wbSel5 <= wbSel;
			aluOp5 <= aluOp;
			branchOp5 <= branchOp;
			jump5 <= jump;
			jumpReg5 <= jumpReg;
			bImm5 <= bImm;
			jImm5 <= jImm;
			uImm5 <= uImm;
			mulDivOp5 <= mulDivOp;
			pc5 <= pc;
			csrOp5 <= csrOp;
			csrAddr5 <= csrAddr;
			csrImm5 <= csrImm;
			ecall5 <= ecall;
		end
	end

	// stage 6, results of the stage 5 blocks
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wbSel6 <= WBALU;
			rdOut <= '0;
			weOut <= 1'b0;
			aluRes6 <= '0;
			mulDiv6 <= '0;
			csr6 <= '0;
			lui6 <= '0;
			auipc6 <= '0;
			link6 <= '0;
		end
		else
		begin
			wbSel6 <= wbSel5;
			rdOut <= rd5;
			weOut <= we5;
			aluRes6 <= aluRes;
			mulDiv6 <= mulDivRes;
			csr6 <= csrOld;	// old value goes to rd
			lui6 <= uImm5;
			auipc6 <= pc5 + uImm5;
			link6 <= pc5 + 32'd4;	// return address for jal/jalr
		end
	end

	always_comb
	begin
		case (wbSel6)
			WBALU: wbData = aluRes6;
			WBLINK: wbData = link6;
			WBMULDIV: wbData = mulDiv6;
			WBLUI: wbData = lui6;
			WBMEM: wbData = memRd;	// dataMem registers its own stage 6
			WBAUIPC: wbData = auipc6;
			WBCSR: wbData = csr6;
			default: wbData = '0;
		endcase
	end

endmodule

// ==== exeStage.sv ====
`timescale 1ns/1ps

module exeStage (
	input logic clk,
	input logic nrst,
	input logic [exePkg::XLEN-1:0] opA,
	input logic [exePkg::XLEN-1:0] opB,
	input logic [4:0] rd,
	input logic we,
	input exePkg::wbSelT wbSel,
	input exePkg::aluOpT aluOp,
	input exePkg::branchOpT branchOp,
	input logic jump,
	input logic jumpReg,
	input logic [exePkg::XLEN-1:0] bImm,
	input logic [exePkg::XLEN-1:0] jImm,
	input logic [exePkg::XLEN-1:0] uImm,
	input logic [exePkg::XLEN-1:0] sImm,
	input exePkg::memOpT memOp,
	input exePkg::mulDivOpT mulDivOp,
	input logic [exePkg::XLEN-1:0] pc,
	input exePkg::csrOpT csrOp,
	input logic [11:0] csrAddr,
	input logic [exePkg::XLEN-1:0] csrImm,
	input logic ecall,
	output logic [exePkg::XLEN-1:0] wbData,
	output logic [4:0] rdOut,
	output logic weOut,
	output logic [exePkg::XLEN-1:0] memOut,
	output logic addrMisaligned,
	output logic [exePkg::XLEN-1:0] target,
	output logic bjTaken,
	output logic pcSelect
);
	import exePkg::*;

	logic [XLEN-1:0] opA5;
	logic [XLEN-1:0] opB5;
	aluOpT aluOp5;
	branchOpT branchOp5;
	mulDivOpT mulDivOp5;
	csrOpT csrOp5;
	logic [11:0] csrAddr5;
	logic [XLEN-1:0] csrImm5;
	logic ecall5;
	logic [XLEN-1:0] pc5;
	logic [XLEN-1:0] bImm5;
	logic [XLEN-1:0] jImm5;
	logic jump5;
	logic jumpReg5;

	logic [XLEN-1:0] aluRes;
	logic btaken;
	logic [XLEN-1:0] mulDivRes;
	logic [XLEN-1:0] csrOld;
	logic [XLEN-1:0] memOffset;

	// stores take the S-type offset, loads carry theirs on opB
	assign memOffset = (memOp inside {SB, SH, SW}) ? sImm : opB;
	assign pcSelect = bjTaken;	// fetch redirect

	exeControl i_control (
		.clk(clk), .nrst(nrst),
		.opA(opA), .opB(opB), .rd(rd), .we(we), .wbSel(wbSel),
		.aluOp(aluOp), .branchOp(branchOp), .jump(jump), .jumpReg(jumpReg),
		.bImm(bImm), .jImm(jImm), .uImm(uImm), .mulDivOp(mulDivOp), .pc(pc),
		.csrOp(csrOp), .csrAddr(csrAddr), .csrImm(csrImm), .ecall(ecall),
		.aluRes(aluRes), .btaken(btaken), .mulDivRes(mulDivRes),
		.csrOld(csrOld), .memRd(memOut),
		.opA5(opA5), .opB5(opB5), .aluOp5(aluOp5), .branchOp5(branchOp5),
		.mulDivOp5(mulDivOp5), .csrOp5(csrOp5), .csrAddr5(csrAddr5),
		.csrImm5(csrImm5), .ecall5(ecall5), .pc5(pc5), .bImm5(bImm5),
		.jImm5(jImm5), .jump5(jump5), .jumpReg5(jumpReg5),
		.wbData(wbData), .rdOut(rdOut), .weOut(weOut)
	);

	alu i_alu (
		.aluOp(aluOp5), .branchOp(branchOp5), .a(opA5), .b(opB5),
		.result(aluRes), .btaken(btaken)
	);

	branchUnit i_branch (
		.pc(pc5), .a(opA5), .bImm(bImm5), .jImm(jImm5), .iImm(opB5),
		.btaken(btaken), .jump(jump5), .jumpReg(jumpReg5),
		.target(target), .bjTaken(bjTaken)
	);

	dataMem i_dmem (
		.clk(clk), .nrst(nrst), .memOp(memOp), .base(opA),
		.storeData(opB), .offset(memOffset),
		.memOut(memOut), .addrMisaligned(addrMisaligned)
	);

	mulDiv i_mulDiv (.a(opA5), .b(opB5), .op(mulDivOp5), .res(mulDivRes));

	csrUnit i_csr (
		.clk(clk), .nrst(nrst), .op(csrOp5), .addr(csrAddr5), .rs1(opA5),
		.imm(csrImm5), .ecall(ecall5), .pc(pc5), .csrOld(csrOld)
	);

endmodule

// ==== exeStageTb.sv ====
`timescale 1ns/1ps

module exeStageTb;
	import exePkg::*;

	localparam string STIMFILE = "exeStim.txt";
	localparam int NFIELDS = 18;	// values per stim line
	localparam int MAXLINES = 64;
	localparam int RESETCYCLES = 10;
	localparam logic [31:0] EMPTYMARK = 32'hffff_ffff;	// never a legal rd

	logic clk;
	logic nrst;
	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [4:0] rd;
	logic we;
	wbSelT wbSel;
	aluOpT aluOp;
	branchOpT branchOp;
	logic jump;
	logic jumpReg;
	logic [XLEN-1:0] bImm;
	logic [XLEN-1:0] jImm;
	logic [XLEN-1:0] uImm;
	logic [XLEN-1:0] sImm;
	memOpT memOp;
	mulDivOpT mulDivOp;
	logic [XLEN-1:0] pc;
	csrOpT csrOp;
	logic [11:0] csrAddr;
	logic [XLEN-1:0] csrImm;
	logic ecall;
	logic [XLEN-1:0] wbData;
	logic [4:0] rdOut;
	logic weOut;
	logic [XLEN-1:0] memOut;
	logic addrMisaligned;
	logic [XLEN-1:0] target;
	logic bjTaken;
	logic pcSelect;

	logic [31:0] stimMem [NFIELDS*MAXLINES];
	int lineCount = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;	// replaced once the stim file is read

	exeStage i_dut (
		.clk(clk), .nrst(nrst), .opA(opA), .opB(opB), .rd(rd), .we(we),
		.wbSel(wbSel), .aluOp(aluOp), .branchOp(branchOp), .jump(jump),
		.jumpReg(jumpReg), .bImm(bImm), .jImm(jImm), .uImm(uImm), .sImm(sImm),
		.memOp(memOp), .mulDivOp(mulDivOp), .pc(pc), .csrOp(csrOp),
		.csrAddr(csrAddr), .csrImm(csrImm), .ecall(ecall),
		.wbData(wbData), .rdOut(rdOut), .weOut(weOut), .memOut(memOut),
		.addrMisaligned(addrMisaligned), .target(target), .bjTaken(bjTaken),
		.pcSelect(pcSelect)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout, the run went past %0d clock cycles", cycleLimit);
			$display("CHECKS FAILED");
			$fatal(1, "run did not finish in time");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		begin
			if (actual !== expected)
			begin
				$display("Error %s: expected %h, actual %h", name, expected, actual);
				$display("CHECKS FAILED");
				$fatal(1, "value mismatch");
			end
		end
	endtask

	task automatic loadStim();
		int fd;
		begin
			fd = $fopen(STIMFILE, "r");
			if (fd == 0)
			begin
				$display("stimulus file %s could not be opened", STIMFILE);
				$display("CHECKS FAILED");
				$fatal(1, "no stimulus");
			end
			else
			begin
				$fclose(fd);
				for (int i = 0; i < NFIELDS*MAXLINES; i++)
					stimMem[i] = EMPTYMARK;
				$readmemh(STIMFILE, stimMem);
				while (lineCount < MAXLINES && stimMem[lineCount*NFIELDS + 4] != EMPTYMARK)
					lineCount++;
				if (lineCount == 0)
				begin
					$display("stimulus file %s holds no instructions", STIMFILE);
					$display("CHECKS FAILED");
					$fatal(1, "empty stimulus");
				end
			end
		end
	endtask

	// a bubble, nothing written and no branch
	task automatic driveIdle();
		begin
			opA = '0;
			opB = '0;
			rd = '0;
			we = 1'b0;
			wbSel = WBALU;
			aluOp = ADD;
			branchOp = NOBR;
			jump = 1'b0;
			jumpReg = 1'b0;
			bImm = '0;
			jImm = '0;
			uImm = '0;
			sImm = '0;
			memOp = MNONE;
			mulDivOp = MUL;
			pc = '0;
			csrOp = CNONE;
			csrAddr = '0;
			csrImm = '0;
			ecall = 1'b0;
		end
	endtask

	task automatic driveLine(input int idx);
		int b;
		begin
			b = idx * NFIELDS;
			opA = stimMem[b];
			opB = stimMem[b+1];
			bImm = stimMem[b+2];	// one imm column feeds every immediate
			jImm = stimMem[b+2];
			uImm = stimMem[b+2];
			sImm = stimMem[b+2];
			csrImm = stimMem[b+2];
			pc = stimMem[b+3];
			rd = stimMem[b+4][4:0];
			we = stimMem[b+5][0];
			wbSel = wbSelT'(stimMem[b+6][2:0]);
			aluOp = aluOpT'(stimMem[b+7][3:0]);
			branchOp = branchOpT'(stimMem[b+8][2:0]);
			memOp = memOpT'(stimMem[b+9][3:0]);
			mulDivOp = mulDivOpT'(stimMem[b+10][2:0]);
			csrOp = csrOpT'(stimMem[b+11][2:0]);
			csrAddr = stimMem[b+12][11:0];
			jump = stimMem[b+13][0];
			jumpReg = stimMem[b+13][1];
			ecall = stimMem[b+13][2];
		end
	endtask

	// one edge after issue
	task automatic checkBranch(input int idx);
		int b;
		begin
			b = idx * NFIELDS;
			checkValue($sformatf("line %0d target", idx), stimMem[b+15], target);
			checkValue($sformatf("line %0d bjTaken", idx), stimMem[b+16], 32'(bjTaken));
			checkValue($sformatf("line %0d pcSelect", idx), stimMem[b+16], 32'(pcSelect));
		end
	endtask

	// two edges after issue
	task automatic checkWriteBack(input int idx);
		int b;
		begin
			b = idx * NFIELDS;
			checkValue($sformatf("line %0d rdOut", idx), stimMem[b+4], 32'(rdOut));
			checkValue($sformatf("line %0d weOut", idx), stimMem[b+5], 32'(weOut));
			if (stimMem[b+5][0])
				checkValue($sformatf("line %0d wbData", idx), stimMem[b+14], wbData);
			// a load shows its value on memOut as well
			if (memOpT'(stimMem[b+9][3:0]) inside {LB, LH, LW, LBU, LHU})
				checkValue($sformatf("line %0d memOut", idx), stimMem[b+14], memOut);
			checkValue($sformatf("line %0d addrMisaligned", idx), stimMem[b+17],
				32'(addrMisaligned));
		end
	endtask

	initial
	begin
		nrst = 1'b0;
		driveIdle();
		loadStim();
		cycleLimit = lineCount + RESETCYCLES + 20;
		repeat (RESETCYCLES) @(posedge clk);
		#1;
		nrst = 1'b1;
		checkValue("reset weOut", 32'd0, 32'(weOut));
		checkValue("reset bjTaken", 32'd0, 32'(bjTaken));
		checkValue("reset addrMisaligned", 32'd0, 32'(addrMisaligned));
		for (int c = 0; c <= lineCount; c++)
		begin
			if (c < lineCount)
				driveLine(c);
			else
				driveIdle();	// drains the last line
			@(posedge clk);
			#1;
			if (c < lineCount)
				checkBranch(c);
			if (c > 0)
				checkWriteBack(c - 1);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== exeStim.txt ====
// opA opB imm pc rd we wbSel aluOp branchOp memOp mulDivOp csrOp csrAddr flags
// flags: bit0 jal, bit1 jalr, bit2 ecall; then expected wbData target bjTaken addrMisaligned
00000005 00000003 00000000 00001000 01 1 0 0 6 0 0 0 000 0 00000008 00001000 0 0
00000003 00000005 00000000 00001004 02 1 0 1 6 0 0 0 000 0 fffffffe 00001004 0 0
ffffffff 00000001 00000000 00001008 03 1 0 3 6 0 0 0 000 0 00000001 00001008 0 0
00000000 00000000 12345000 0000100c 04 1 3 0 6 0 0 0 000 0 12345000 1234600c 0 0
00000000 00000000 00002000 00001010 05 1 5 0 6 0 0 0 000 0 00003010 00003010 0 0
00000007 00000007 00000010 00001014 00 0 0 0 0 0 0 0 000 0 00000000 00001024 1 0
00000005 fffffffb fffffff0 00001018 00 0 0 0 2 0 0 0 000 0 00000000 00001008 0 0
00000005 fffffffb 00000020 0000101c 00 0 0 0 4 0 0 0 000 0 00000000 0000103c 1 0
00000000 00000000 00000100 00001020 01 1 1 0 6 0 0 0 000 1 00001024 00001120 1 0
00002001 00000004 00000000 00001024 01 1 1 0 6 0 0 0 000 2 00001028 00002004 1 0
00012345 00001000 00000000 00001028 07 1 2 0 6 0 0 0 000 0 12345000 00001028 0 0
ffffffff ffffffff 00000000 0000102c 08 1 2 0 6 0 3 0 000 0 fffffffe 0000102c 0 0
00000064 00000000 00000000 00001030 09 1 2 0 6 0 4 0 000 0 ffffffff 00001030 0 0
80000000 ffffffff 00000000 00001034 0a 1 2 0 6 0 4 0 000 0 80000000 00001034 0 0
fffffff9 00000002 00000000 00001038 0b 1 2 0 6 0 6 0 000 0 ffffffff 00001038 0 0
0000002a 00000000 00000000 0000103c 0c 1 2 0 6 0 7 0 000 0 0000002a 0000103c 0 0
00000100 11223344 00000000 00001040 00 0 0 0 6 8 0 0 000 0 00000000 00001040 0 0
00000100 000000aa 00000001 00001044 00 0 0 0 6 6 0 0 000 0 00000000 00001045 0 0
00000100 0000beef 00000002 00001048 00 0 0 0 6 7 0 0 000 0 00000000 0000104a 0 0
00000100 00000001 00000000 0000104c 0d 1 4 0 6 1 0 0 000 0 ffffffaa 0000104c 0 0
00000100 00000001 00000000 00001050 0e 1 4 0 6 4 0 0 000 0 000000aa 00001050 0 0
00000100 00000002 00000000 00001054 0f 1 4 0 6 2 0 0 000 0 ffffbeef 00001054 0 0
00000100 00000000 00000000 00001058 10 1 4 0 6 3 0 0 000 0 beefaa44 00001058 0 0
00000100 deadbeef 00000002 0000105c 00 0 0 0 6 8 0 0 000 0 00000000 0000105e 0 1
00000100 00000000 00000000 00001060 11 1 4 0 6 3 0 0 000 0 beefaa44 00001060 0 0
a5a5a5a5 00000000 00000000 00001064 12 1 6 0 6 0 0 1 340 0 00000000 00001064 0 0
0000000f 00000000 00000000 00001068 13 1 6 0 6 0 0 2 340 0 a5a5a5a5 00001068 0 0
000000ff 00000000 00000000 0000106c 14 1 6 0 6 0 0 3 340 0 a5a5a5af 0000106c 0 0
00000000 00000000 00000000 00001070 15 1 6 0 6 0 0 2 340 0 a5a5a500 00001070 0 0
00000000 00000000 00000000 00001074 00 0 0 0 6 0 0 0 000 4 00000000 00001074 0 0
00000000 00000000 00000000 00001078 16 1 6 0 6 0 0 2 341 0 00001074 00001078 0 0
00000000 00000000 00000000 0000107c 17 1 6 0 6 0 0 2 342 0 0000000b 0000107c 0 0

// ==== flist.f ====
exePkg.sv
alu.sv
branchUnit.sv
dataMem.sv
mulDiv.sv
csrUnit.sv
exeControl.sv
exeStage.sv
exeStageTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
verilator --binary --timing --top-module exeStageTb -f flist.f -o simExe
./obj_dir/simExe > sim.log 2>&1 || true
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	exit 1
fi
